// ==== sources.f ====
src/cachePkg.sv
src/busPkg.sv
src/reqDecoder.sv
src/tagStore.sv
src/lineStore.sv
src/missController.sv
src/respMux.sv
src/dmCache.sv
testbench/dmCache_checker.sv
testbench/dmCacheTb.sv

// ==== testbench/dmCacheTb.sv ====
`timescale 1ns/1ps

module dmCacheTb
	import cachePkg::*;
	import busPkg::*;
();

	localparam int timeoutCycles = 300 * 25; // requests times worst cycles each.

	logic clk;
	logic rstN;
	logic reqValid;
	logic reqWrite;
	cacheAddrU reqAddr;
	wordT reqWriteData;
	logic busy;
	logic respValid;
	wordT respReadData;
	logic memReq;
	memReqT memReqData;
	logic memAck;
	lineT memReadLine;

	integer seed = 32'hbdca;
	int cycleCount = 0;
	int memReqCount = 0; // every memory transaction.
	int memWriteCount = 0; // writebacks only.
	lineT memLines [lineAddrT]; // backing memory holding written lines only.
	wordT shadow [bit [addrWidth-1:0]]; // client view of every written word.

	dmCache i_dmCache (
		.clk, .rstN, .reqValid, .reqWrite, .reqAddr, .reqWriteData, .busy, .respValid,
		.respReadData, .memReq, .memReqData, .memAck, .memReadLine
	);

	initial begin
		clk = 1'b0;
		forever begin
			#10 clk = ~clk; // 20 ns period.
		end
	end

	// unwritten memory reads as the address with a marker in the top half.
	function automatic wordT initialWord(input logic [addrWidth-1:0] addr);
		return {16'h0000, addr} ^ 32'h5a5a0000;
	endfunction

	function automatic wordT expectedWord(input logic [addrWidth-1:0] addr);
		if (shadow.exists(addr)) begin
			return shadow[addr];
		end
		return initialWord(addr);
	endfunction

	// what a writeback of this line must carry.
	function automatic lineT expectedLine(input lineAddrT lineAddr);
		lineT result;
		for (int w = 0; w < lineWords; w++) begin
			result[w] = expectedWord({lineAddr, 2'(w)});
		end
		return result;
	endfunction

	function automatic lineT memoryLine(input lineAddrT lineAddr);
		lineT result;
		if (memLines.exists(lineAddr)) begin
			return memLines[lineAddr];
		end
		for (int w = 0; w < lineWords; w++) begin
			result[w] = initialWord({lineAddr, 2'(w)});
		end
		return result;
	endfunction

	task automatic mismatch(
		input string testName,
		input logic [127:0] expected,
		input logic [127:0] actual
	);
		$display("** Error %s: expected %0h, actual %0h", testName, expected, actual);
		$display("Checks failed");
		$fatal(1, "%s mismatch", testName);
	endtask

	task automatic fault(input string what);
		$display("Error: %s", what);
		$display("Checks failed");
		$fatal(1, "run stopped");
	endtask

	// one request from a falling edge up to the falling edge that sees respValid.
	task automatic access(
		input string testName,
		input bit write,
		input logic [addrWidth-1:0] addr,
		input wordT writeData,
		output int latency,
		output int reqs,
		output int writes
	);
		int startCycle;
		int reqsBefore;
		int writesBefore;
		wordT expected;
		expected = write ? writeData : expectedWord(addr); // stores echo their data.
		reqsBefore = memReqCount;
		writesBefore = memWriteCount;
		reqValid = 1'b1;
		reqWrite = write;
		reqAddr.raw = addr;
		reqWriteData = writeData;
		startCycle = cycleCount;
		@(negedge clk);
		reqValid = 1'b0; // strobe taken on the edge just passed.
		while (!respValid) begin
			@(negedge clk);
		end
		latency = cycleCount - startCycle - 1; // edges after the strobe edge.
		reqs = memReqCount - reqsBefore;
		writes = memWriteCount - writesBefore;
		assert (respReadData == expected) else mismatch(testName, expected, respReadData);
		if (write) begin
			shadow[addr] = writeData;
		end
	endtask

	// memory model answering each request after 1 to 8 cycles.
	initial begin
		memReqT pending;
		int delay;
		memAck = 1'b0;
		memReadLine = '0;
		forever begin
			@(negedge clk);
			memAck = 1'b0;
			if (memReq) begin
				pending = memReqData;
				memReqCount++;
				if (pending.write) begin
					memWriteCount++;
					assert (pending.writeLine == expectedLine(pending.lineAddr)) else
						mismatch("writeback line", expectedLine(pending.lineAddr),
							pending.writeLine);
					memLines[pending.lineAddr] = pending.writeLine;
				end
				delay = 1 + {$random(seed)} % 8;
				repeat (delay - 1) @(negedge clk);
				memAck = 1'b1; // sampled on the next rising edge.
				memReadLine = pending.write ? '0 : memoryLine(pending.lineAddr);
			end
		end
	end

	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= timeoutCycles) begin
			$display("Timeout: run did not finish within %0d cycles", timeoutCycles);
			$display("Checks failed");
			$fatal(1, "timeout");
		end
	end

	// the bound checker counts its own failures.
	always @(negedge clk) begin
		if (i_dmCache.i_checker.failCount != 0) begin
			$display("Error: a bound protocol assertion failed");
			$display("Checks failed");
			$fatal(1, "protocol assertion");
		end
	end

	initial begin
		int latency;
		int reqs;
		int writes;
		bit isWrite;
		logic [addrWidth-1:0] addr;
		rstN = 1'b0;
		reqValid = 1'b0;
		reqWrite = 1'b0;
		reqAddr = '0;
		reqWriteData = '0;
		repeat (16) @(negedge clk);
		assert (!busy && !respValid && !memReq) else fault("outputs active in reset");
		rstN = 1'b1;
		@(negedge clk);
		assert (!busy && !respValid && !memReq) else fault("outputs active after reset");

		// cold read goes to memory once.
		access("first read", 1'b0, 16'h0123, '0, latency, reqs, writes);
		assert (reqs == 1) else mismatch("first read requests", 1, reqs);
		assert (writes == 0) else mismatch("first read writes", 0, writes);

		access("write then read", 1'b1, 16'h0123, 32'hcafe0001, latency, reqs, writes);
		access("write then read", 1'b0, 16'h0123, '0, latency, reqs, writes);
		assert (reqs == 0) else mismatch("write then read requests", 0, reqs);
		assert (latency == 2) else mismatch("hit latency", 2, latency);

		// same index with tag 0 instead of 1.
		access("conflict", 1'b0, 16'h0023, '0, latency, reqs, writes);
		assert (reqs == 2) else mismatch("conflict requests", 2, reqs);
		assert (writes == 1) else mismatch("conflict writes", 1, writes);
		access("writeback reload", 1'b0, 16'h0123, '0, latency, reqs, writes);
		assert (writes == 0) else mismatch("writeback reload writes", 0, writes);

		access("clean evict", 1'b0, 16'h0240, '0, latency, reqs, writes);
		access("clean evict", 1'b0, 16'h0340, '0, latency, reqs, writes);
		assert (writes == 0) else mismatch("clean evict writes", 0, writes);
		access("dirty evict", 1'b1, 16'h0480, 32'h1234abcd, latency, reqs, writes);
		access("dirty evict", 1'b0, 16'h0580, '0, latency, reqs, writes);
		assert (writes == 1) else mismatch("dirty evict writes", 1, writes);

		// 4 tags over 4 indexes keeps conflicts frequent.
		for (int n = 0; n < 250; n++) begin
			addr = {6'b0, 2'($random(seed)), 4'b0, 2'($random(seed)), 2'($random(seed))};
			isWrite = 1'($random(seed));
			access("random", isWrite, addr, $random(seed), latency, reqs, writes);
		end

		repeat (4) @(negedge clk);
		if (i_dmCache.i_checker.failCount != 0) begin
			$display("Checks failed");
			$fatal(1, "protocol assertion");
		end else begin
			$display("All checks passed");
			$finish;
		end
	end

endmodule

// ==== testbench/dmCache_checker.sv ====
`timescale 1ns/1ps

module dmCache_checker (
	input logic clk,
	input logic rstN,
	input logic busy,
	input logic respValid,
	input logic memReq,
	input logic memAck
);

	int unsigned failCount = 0; // read by the testbench monitor.

	// async reset holds every control output low.
	resetQuiet: assert property (@(posedge clk) !rstN |-> (!busy && !respValid && !memReq))
		else begin
			failCount++;
			$error("control outputs active during reset");
		end

	// the refill read may follow a writeback directly when its ack came in the pulse cycle.
	memReqPulse: assert property (@(posedge clk) disable iff (!rstN)
		(memReq && !memAck) |=> !memReq)
		else begin
			failCount++;
			$error("memReq held longer than one cycle");
		end

	respPulse: assert property (@(posedge clk) disable iff (!rstN) respValid |=> !respValid)
		else begin
			failCount++;
			$error("respValid held longer than one cycle");
		end

	// busy drops on the edge respValid rises and needs a look one cycle back.
	respInBusy: assert property (@(posedge clk) disable iff (!rstN) respValid |-> $past(busy))
		else begin
			failCount++;
			$error("respValid without a request in flight");
		end

	memReqBusy: assert property (@(posedge clk) disable iff (!rstN) memReq |-> busy)
		else begin
			failCount++;
			$error("memReq issued while the cache was idle");
		end

endmodule

bind dmCache dmCache_checker i_checker (.clk, .rstN, .busy, .respValid, .memReq, .memAck);

// ==== src/dmCache.sv ====
`timescale 1ns/1ps

module dmCache
	import cachePkg::*;
	import busPkg::*;
(
	input  logic      clk,
	input  logic      rstN,
	input  logic      reqValid,
	input  logic      reqWrite,
	input  cacheAddrU reqAddr,
	input  wordT      reqWriteData,
	output logic      busy,
	output logic      respValid,
	output wordT      respReadData,
	output logic      memReq,
	output memReqT    memReqData,
	input  logic      memAck,
	input  lineT      memReadLine
);

	logic start;
	cacheReqT req;
	logic done;
	logic [indexWidth-1:0] index;
	logic [tagWidth-1:0] lookupTag;
	logic hit;
	tagEntryT victim;
	logic install;
	logic [tagWidth-1:0] installTag;
	logic setDirty;
	logic fillEnable;
	lineT fillLine;
	logic wordEnable;
	logic [offsetWidth-1:0] wordOffset;
	wordT wordData;
	lineT line;

	// client input side.
	reqDecoder i_reqDecoder (
		.clk, .rstN, .reqValid, .reqWrite, .reqAddr, .reqWriteData, .done,
		.start, .req, .busy
	);

	tagStore i_tagStore (
		.clk, .rstN, .index, .lookupTag, .install, .installTag, .setDirty,
		.hit, .victim
	);

	lineStore i_lineStore (
		.clk, .index, .fillEnable, .fillLine, .wordEnable, .wordOffset, .wordData,
		.line
	);

	// owns the memory port.
	missController i_missController (
		.clk, .rstN, .start, .req, .hit, .victim, .line, .memAck, .memReadLine,
		.index, .lookupTag, .install, .installTag, .setDirty, .fillEnable, .fillLine,
		.wordEnable, .wordOffset, .wordData, .memReq, .memReqData, .done
	);

	respMux i_respMux (
		.clk, .rstN, .done, .req, .line, .respValid, .respReadData
	);

endmodule

// ==== src/respMux.sv ====
`timescale 1ns/1ps

module respMux
	import cachePkg::*;
	import busPkg::*;
(
	input  logic     clk,
	input  logic     rstN,
	input  logic     done, // lookup hit in this cycle.
	input  cacheReqT req,
	input  lineT     line, // line at the request's index.
	output logic     respValid,
	output wordT     respReadData
);

	wordT selWord;

	// stores echo the word they wrote, loads pick the word at the offset.
	assign selWord = req.write ? req.writeData : line[req.addr.fields.offset];

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			respValid <= 1'b0;
		end else begin
			respValid <= done; // one-cycle pulse, done never repeats back to back.
		end
	end

	// data holds until the next response.
	always_ff @(posedge clk) begin
		if (done) begin
			respReadData <= selWord;
		end
	end

endmodule

// ==== src/missController.sv ====
`timescale 1ns/1ps

module missController
	import cachePkg::*;
	import busPkg::*;
(
	input  logic                   clk,
	input  logic                   rstN,
	input  logic                   start, // new request registered.
	input  cacheReqT               req,
	input  logic                   hit,
	input  tagEntryT               victim,
	input  lineT                   line, // current contents of the indexed line.
	input  logic                   memAck,
	input  lineT                   memReadLine, // valid with memAck on a read.
	output logic [indexWidth-1:0]  index,
	output logic [tagWidth-1:0]    lookupTag,
	output logic                   install,
	output logic [tagWidth-1:0]    installTag,
	output logic                   setDirty,
	output logic                   fillEnable,
	output lineT                   fillLine,
	output logic                   wordEnable,
	output logic [offsetWidth-1:0] wordOffset,
	output wordT                   wordData,
	output logic                   memReq, // one pulse per transaction.
	output memReqT                 memReqData,
	output logic                   done
);

	typedef enum logic [2:0] {
		idle,
		lookup,
		writeBack, // waiting for the victim write to be taken.
		refill, // waiting for the line read.
		finish
	} stateT;

	stateT state;
	stateT nextState;
	logic victimDirty;
	logic issueWb;
	logic issueRead;

	// every store is addressed by the held request.
	assign index = req.addr.fields.index;
	assign lookupTag = req.addr.fields.tag;
	assign installTag = req.addr.fields.tag;
	assign wordOffset = req.addr.fields.offset;
	assign wordData = req.writeData;
	assign fillLine = memReadLine;

	assign victimDirty = victim.valid && victim.dirty;

	// a miss on a dirty line saves it first, otherwise go straight to the read.
	assign issueWb = (state == lookup) && !hit && victimDirty;
	assign issueRead = ((state == lookup) && !hit && !victimDirty) ||
		((state == writeBack) && memAck);

	// completion happens only out of lookup.
	assign done = (state == lookup) && hit;
	assign wordEnable = done && req.write;
	assign setDirty = done && req.write;

	// refill data lands in the same cycle as its ack.
	assign fillEnable = (state == refill) && memAck;
	assign install = (state == refill) && memAck;

	always_comb begin
		nextState = state;
		case (state)
			idle: if (start) nextState = lookup;
			lookup: begin
				if (hit) begin
					nextState = idle;
				end else if (victimDirty) begin
					nextState = writeBack;
				end else begin
					nextState = refill;
				end
			end
			writeBack: if (memAck) nextState = refill;
			refill: if (memAck) nextState = finish;
			finish: nextState = lookup; // retry, the entry is installed now.
			default: nextState = idle;
		endcase
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			state <= idle;
			memReq <= 1'b0;
		end else begin
			state <= nextState;
			memReq <= issueWb || issueRead; // registered, so a clean pulse.
		end
	end

	// transaction payload, captured alongside the pulse.
	always_ff @(posedge clk) begin
		if (issueWb) begin
			memReqData.write <= 1'b1;
			memReqData.lineAddr <= {victim.tag, index}; // victim's own address.
			memReqData.writeLine <= line;
		end else if (issueRead) begin
			memReqData.write <= 1'b0;
			memReqData.lineAddr <= {lookupTag, index};
			memReqData.writeLine <= '0;
		end
	end

endmodule

// ==== src/lineStore.sv ====
`timescale 1ns/1ps

module lineStore
	import cachePkg::*;
	import busPkg::*;
(
	input  logic                   clk,
	input  logic [indexWidth-1:0]  index,
	input  logic                   fillEnable, // replace the whole line.
	input  lineT                   fillLine,
	input  logic                   wordEnable, // merge a single word.
	input  logic [offsetWidth-1:0] wordOffset,
	input  wordT                   wordData,
	output lineT                   line // indexed line, combinational.
);

	// data array, one line per index.
	lineT lines [numLines];

	// refill has priority, the controller never raises both anyway.
	always_ff @(posedge clk) begin
		if (fillEnable) begin
			lines[index] <= fillLine;
		end else if (wordEnable) begin
			lines[index][wordOffset] <= wordData; // other words untouched.
		end
	end

	// read port feeds the response mux and the writeback path.
	assign line = lines[index];

endmodule

// ==== src/tagStore.sv ====
`timescale 1ns/1ps

module tagStore import cachePkg::*; (
	input  logic                  clk,
	input  logic                  rstN,
	input  logic [indexWidth-1:0] index, // line being looked up or written.
	input  logic [tagWidth-1:0]   lookupTag,
	input  logic                  install, // refill done, write clean entry.
	input  logic [tagWidth-1:0]   installTag,
	input  logic                  setDirty, // write hit on the indexed line.
	output logic                  hit,
	output tagEntryT              victim // current occupant of the indexed line.
);

	logic [numLines-1:0] validQ;
	logic [numLines-1:0] dirtyQ;
	logic [tagWidth-1:0] tagQ [numLines];

	// valid bits come up cleared so every line starts empty.
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			validQ <= '0;
		end else if (install) begin
			validQ[index] <= 1'b1;
		end
	end

	// dirty bits only matter behind a set valid bit.
	always_ff @(posedge clk) begin
		if (install) begin
			dirtyQ[index] <= 1'b0; // fresh line matches memory.
		end else if (setDirty) begin
			dirtyQ[index] <= 1'b1;
		end
	end

	// tag array.
	always_ff @(posedge clk) begin
		if (install) begin
			tagQ[index] <= installTag;
		end
	end

	// combinational read of the indexed entry.
	always_comb begin
		victim.valid = validQ[index];
		victim.dirty = dirtyQ[index];
		victim.tag = tagQ[index];
	end

	// hit needs both a live line and a matching tag.
	assign hit = victim.valid && (victim.tag == lookupTag);

endmodule

// ==== src/reqDecoder.sv ====
`timescale 1ns/1ps

module reqDecoder import cachePkg::*; (
	input  logic      clk,
	input  logic      rstN,
	input  logic      reqValid, // client strobe.
	input  logic      reqWrite,
	input  cacheAddrU reqAddr,
	input  wordT      reqWriteData,
	input  logic      done, // controller finished the request.
	output logic      start, // one-cycle pulse per accepted request.
	output cacheReqT  req,
	output logic      busy
);

	logic accept;

	// strobes are ignored while a request is in flight.
	assign accept = reqValid && !busy;

	// control side.
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			start <= 1'b0;
			busy <= 1'b0;
		end else begin
			start <= accept; // pulse, accept cannot repeat while busy.
			if (accept) begin
				busy <= 1'b1;
			end else if (done) begin
				busy <= 1'b0; // drops on the same edge respValid rises.
			end
		end
	end

	// request register, held stable until the next acceptance.
	always_ff @(posedge clk) begin
		if (accept) begin
			req.write <= reqWrite;
			req.addr <= reqAddr;
			req.writeData <= reqWriteData;
		end
	end

endmodule

// ==== src/busPkg.sv ====
package busPkg;

	// memory port moves whole lines only.
	localparam int lineWords = 4;
	localparam int busWordWidth = 32;
	localparam int lineAddrWidth = 14; // tag and index, no offset.

	// word 0 sits in the low bits.
	typedef logic [lineWords-1:0][busWordWidth-1:0] lineT;

	typedef logic [lineAddrWidth-1:0] lineAddrT;

	// one memory transaction.
	typedef struct packed {
		logic write; // 1 = writeback, 0 = refill read.
		lineAddrT lineAddr;
		lineT writeLine; // only meaningful for writebacks.
	} memReqT;

endpackage

// ==== src/cachePkg.sv ====
package cachePkg;

	// cache geometry, word addressed.
	localparam int addrWidth = 16; // flat word address.
	localparam int wordWidth = 32;
	localparam int offsetWidth = 2; // 4 words per line.
	localparam int indexWidth = 6;
	localparam int tagWidth = 8;
	localparam int numLines = 64; // one line per index value.

	typedef logic [wordWidth-1:0] wordT;

	// address split as the stores see it, msb first.
	typedef struct packed {
		logic [tagWidth-1:0] tag;
		logic [indexWidth-1:0] index;
		logic [offsetWidth-1:0] offset;
	} addrFieldsT;

	// one address word, read either flat or split into fields.
	typedef union packed {
		logic [addrWidth-1:0] raw; // client and memory view.
		addrFieldsT fields; // tag store, line store and controller view.
	} cacheAddrU;

	// per-line bookkeeping.
	typedef struct packed {
		logic valid;
		logic dirty; // line differs from memory.
		logic [tagWidth-1:0] tag;
	} tagEntryT;

	// one client request as held while the cache works on it.
	typedef struct packed {
		logic write; // 1 = store, 0 = load.
		cacheAddrU addr;
		wordT writeData; // unused for loads.
	} cacheReqT;

endpackage
